/* include/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and program memory sizes
`define CPU_DATA_W     8
`define CPU_ADDR_W     8
`define CPU_MEM_DEPTH  256
`define CPU_REG_IDX_W  2
`define CPU_OP_W       4

// Opcode values held in instruction bits 7:4
`define CPU_OP_NOP  4'd0
`define CPU_OP_LDI  4'd1
`define CPU_OP_MOV  4'd2
`define CPU_OP_ADD  4'd3
`define CPU_OP_ADC  4'd4
`define CPU_OP_SUB  4'd5
`define CPU_OP_AND  4'd6
`define CPU_OP_OR   4'd7
`define CPU_OP_XOR  4'd8
`define CPU_OP_HLT  4'd15

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0]    data_t;
  typedef logic [`CPU_ADDR_W-1:0]    addr_t;
  typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`CPU_OP_W-1:0]      opcode_t;

  // One decoded instruction, LDI carries its constant byte along
  typedef struct packed {
    logic     valid;
    opcode_t  opcode;
    reg_idx_t dst;
    reg_idx_t src;
    data_t    constant;
  } decoded_t;

  // Status bits from the execute stage
  typedef struct packed {
    logic halt;
    logic negative;
    logic carry;
  } flags_t;

  // Whether the next fetched byte is an opcode or an LDI constant
  typedef enum logic {
    expect_opcode,
    expect_constant
  } dec_state_e;

endpackage

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

`include "cpu_macros.svh"

module fetch_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           halt,
  input  logic           prog_we,
  input  cpu_pkg::addr_t prog_addr,
  input  cpu_pkg::data_t prog_data,
  output logic           fetch_valid,
  output cpu_pkg::data_t fetch_byte,
  output cpu_pkg::addr_t pc
);
  import cpu_pkg::*;

  data_t prog_mem [`CPU_MEM_DEPTH];

  // Program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  // Synchronous read, byte at pc shows up one cycle later
  always_ff @(posedge clk) begin
    fetch_byte <= prog_mem[pc];
  end

  // Program counter runs freely until the halt flag comes back from execute
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b1;
      if (!halt) begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`default_nettype none

`include "cpu_macros.svh"

module instr_decoder (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetch_valid,
  input  cpu_pkg::data_t   fetch_byte,
  output cpu_pkg::decoded_t decoded
);
  import cpu_pkg::*;

  dec_state_e state;
  logic       dec_valid;
  opcode_t    dec_opcode;
  reg_idx_t   dec_dst;
  reg_idx_t   dec_src;
  data_t      dec_constant;

  opcode_t    byte_opcode;
  logic       byte_is_ldi;

  // Unknown codes are turned into NOP here so execute sees only legal ones
  function automatic opcode_t legal_opcode(input opcode_t op);
    case (op)
      `CPU_OP_LDI, `CPU_OP_MOV, `CPU_OP_ADD, `CPU_OP_ADC, `CPU_OP_SUB,
      `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR, `CPU_OP_HLT: begin
        legal_opcode = op;
      end
      default: begin
        legal_opcode = `CPU_OP_NOP;
      end
    endcase
  endfunction

  assign byte_opcode = fetch_byte[7:4];
  assign byte_is_ldi = (byte_opcode == `CPU_OP_LDI);

  // Constant byte FSM and output valid
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= expect_opcode;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= 1'b0;
      if (fetch_valid) begin
        case (state)
          expect_opcode: begin
            // LDI waits for its constant and leaves an empty slot
            if (byte_is_ldi) begin
              state <= expect_constant;
            end else begin
              dec_valid <= 1'b1;
            end
          end
          expect_constant: begin
            state     <= expect_opcode;
            dec_valid <= 1'b1;
          end
          default: begin
            state <= expect_opcode;
          end
        endcase
      end
    end
  end

  // Fields are captured from the opcode byte and held over the constant byte
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      if (state == expect_opcode) begin
        dec_opcode <= legal_opcode(byte_opcode);
        dec_dst    <= fetch_byte[3:2];
        dec_src    <= fetch_byte[1:0];
      end else begin
        dec_constant <= fetch_byte;
      end
    end
  end

  assign decoded = '{
    valid:    dec_valid,
    opcode:   dec_opcode,
    dst:      dec_dst,
    src:      dec_src,
    constant: dec_constant
  };

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`default_nettype none

`include "cpu_macros.svh"

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::decoded_t decoded,
  output cpu_pkg::flags_t   flags,
  output cpu_pkg::data_t    reg_a,
  output cpu_pkg::data_t    reg_b,
  output cpu_pkg::data_t    reg_c,
  output cpu_pkg::data_t    reg_d
);
  import cpu_pkg::*;

  localparam int NUM_REGS = 1 << `CPU_REG_IDX_W;

  data_t  regs [NUM_REGS];
  flags_t flags_q;

  data_t  lhs;
  data_t  rhs;
  logic [`CPU_DATA_W:0] alu_wide;
  data_t  alu_result;
  logic   alu_carry;
  logic   is_alu_op;

  // dst is the left operand, src the right
  assign lhs = regs[decoded.dst];
  assign rhs = regs[decoded.src];

  // ALU, bit 8 of the wide result is carry out or borrow
  always_comb begin
    alu_wide  = '0;
    is_alu_op = 1'b1;
    case (decoded.opcode)
      `CPU_OP_ADD: alu_wide = {1'b0, lhs} + {1'b0, rhs};
      `CPU_OP_ADC: begin
        alu_wide = {1'b0, lhs} + {1'b0, rhs} + {{`CPU_DATA_W{1'b0}}, flags_q.carry};
      end
      // Borrow set when lhs < rhs
      `CPU_OP_SUB: alu_wide = {1'b0, lhs} - {1'b0, rhs};
      `CPU_OP_AND: alu_wide = {1'b0, lhs & rhs};
      `CPU_OP_OR:  alu_wide = {1'b0, lhs | rhs};
      `CPU_OP_XOR: alu_wide = {1'b0, lhs ^ rhs};
      default:     is_alu_op = 1'b0;
    endcase
  end

  assign alu_result = alu_wide[`CPU_DATA_W-1:0];
  assign alu_carry  = alu_wide[`CPU_DATA_W];

  // Writeback, nothing changes once halted
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      flags_q <= '0;
    end else if (decoded.valid && !flags_q.halt) begin
      case (decoded.opcode)
        `CPU_OP_LDI: regs[decoded.dst] <= decoded.constant;
        `CPU_OP_MOV: regs[decoded.dst] <= rhs;
        `CPU_OP_HLT: flags_q.halt <= 1'b1;
        default: begin
          // NOP falls through with is_alu_op low
          if (is_alu_op) begin
            regs[decoded.dst] <= alu_result;
            flags_q.carry     <= alu_carry;
            flags_q.negative  <= alu_result[`CPU_DATA_W-1];
          end
        end
      endcase
    end
  end

  assign flags = flags_q;
  assign reg_a = regs[0];
  assign reg_b = regs[1];
  assign reg_c = regs[2];
  assign reg_d = regs[3];

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none

module cpu_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            prog_we,
  input  cpu_pkg::addr_t  prog_addr,
  input  cpu_pkg::data_t  prog_data,
  output cpu_pkg::data_t  reg_a,
  output cpu_pkg::data_t  reg_b,
  output cpu_pkg::data_t  reg_c,
  output cpu_pkg::data_t  reg_d,
  output cpu_pkg::flags_t flags,
  output cpu_pkg::addr_t  pc,
  output logic            halt
);
  import cpu_pkg::*;

  logic     fetch_valid;
  data_t    fetch_byte;
  decoded_t decoded;

  // Producer, program memory and PC
  fetch_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .halt        (flags.halt),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .fetch_valid (fetch_valid),
    .fetch_byte  (fetch_byte),
    .pc          (pc)
  );

  // Pipeline register
  instr_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_byte  (fetch_byte),
    .decoded     (decoded)
  );

  // Consumer, register file and ALU
  execute_unit u_execute (
    .clk     (clk),
    .reset   (reset),
    .decoded (decoded),
    .flags   (flags),
    .reg_a   (reg_a),
    .reg_b   (reg_b),
    .reg_c   (reg_c),
    .reg_d   (reg_d)
  );

  assign halt = flags.halt;

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS    = 6;
  localparam int MAX_PROG     = 24;
  localparam int HOLD_CYCLES  = 10;
  // Reset, full memory load, program, drain slack and the hold check for every test
  localparam int TEST_CYCLES  = RESET_CYCLES + `CPU_MEM_DEPTH + MAX_PROG + 20 + HOLD_CYCLES;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES;

  localparam reg_idx_t IDX_A = 2'd0;
  localparam reg_idx_t IDX_B = 2'd1;
  localparam reg_idx_t IDX_C = 2'd2;
  localparam reg_idx_t IDX_D = 2'd3;

  logic    clk = 1'b0;
  logic    reset;
  logic    prog_we;
  addr_t   prog_addr;
  data_t   prog_data;
  data_t   reg_a;
  data_t   reg_b;
  data_t   reg_c;
  data_t   reg_d;
  flags_t  flags;
  addr_t   pc;
  logic    halt;

  data_t       prog [$];
  data_t       image [`CPU_MEM_DEPTH];
  data_t       exp_regs [4];
  logic        exp_carry;
  logic        exp_neg;
  addr_t       exp_pc;
  logic [31:0] lcg_state = 32'd38;
  int          test_num = 0;
  int          test_errors;
  int          tests_passed = 0;
  int          tests_failed = 0;

  cpu_top DUT (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .reg_a     (reg_a),
    .reg_b     (reg_b),
    .reg_c     (reg_c),
    .reg_d     (reg_d),
    .flags     (flags),
    .pc        (pc),
    .halt      (halt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic data_t rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic emit(input opcode_t op, input reg_idx_t dst, input reg_idx_t src);
    prog.push_back({op, dst, src});
  endtask

  task automatic emit_ldi(input reg_idx_t dst, input data_t value);
    prog.push_back({`CPU_OP_LDI, dst, 2'b00});
    prog.push_back(value);
  endtask

  task automatic check_value(input string name, input data_t got, input data_t expected);
    assert (got === expected) else begin
      $display("error: %s got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic alu_writeback(input reg_idx_t dst, input data_t value);
    exp_regs[dst] = value;
    exp_neg       = value[7];
  endtask

  // Instruction-level model that stops at the first HLT
  task automatic run_model();
    int         i;
    int         step_len;
    opcode_t    op;
    reg_idx_t   d;
    reg_idx_t   s;
    data_t      lhs;
    data_t      rhs;
    logic [8:0] wide;
    logic       stop;
    for (int r = 0; r < 4; r++) begin
      exp_regs[r] = '0;
    end
    exp_carry = 1'b0;
    exp_neg   = 1'b0;
    stop      = 1'b0;
    i         = 0;
    while (!stop && i < `CPU_MEM_DEPTH - 1) begin
      op       = image[i][7:4];
      d        = image[i][3:2];
      s        = image[i][1:0];
      lhs      = exp_regs[d];
      rhs      = exp_regs[s];
      step_len = 1;
      case (op)
        `CPU_OP_LDI: begin
          exp_regs[d] = image[i + 1];
          step_len    = 2;
        end
        `CPU_OP_MOV: exp_regs[d] = rhs;
        `CPU_OP_ADD, `CPU_OP_ADC: begin
          wide = {1'b0, lhs} + {1'b0, rhs};
          if (op == `CPU_OP_ADC) begin
            wide = wide + {8'b0, exp_carry};
          end
          exp_carry = wide[8];
          alu_writeback(d, wide[7:0]);
        end
        `CPU_OP_SUB: begin
          exp_carry = (lhs < rhs);
          alu_writeback(d, lhs - rhs);
        end
        `CPU_OP_AND: begin
          exp_carry = 1'b0;
          alu_writeback(d, lhs & rhs);
        end
        `CPU_OP_OR: begin
          exp_carry = 1'b0;
          alu_writeback(d, lhs | rhs);
        end
        `CPU_OP_XOR: begin
          exp_carry = 1'b0;
          alu_writeback(d, lhs ^ rhs);
        end
        `CPU_OP_HLT: begin
          stop   = 1'b1;
          // One cycle each for fetch, decode and execute before pc freezes
          exp_pc = addr_t'(i + 3);
        end
        default: ;
      endcase
      i += step_len;
    end
  endtask

  task automatic run_test(input string name, input logic check_hold);
    addr_t fill_addr;
    addr_t hold_pc;
    int    cycles;
    test_num++;
    test_errors = 0;
    // HLT codes with the address folded into the register fields
    for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
      fill_addr = addr_t'(a);
      if (a < prog.size()) begin
        image[a] = prog[a];
      end else begin
        image[a] = {`CPU_OP_HLT, fill_addr[7:4] ^ fill_addr[3:0]};
      end
    end
    reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
      prog_we   = 1'b1;
      prog_addr = addr_t'(a);
      prog_data = image[a];
      next_cycle();
    end
    prog_we = 1'b0;
    run_model();
    reset  = 1'b0;
    cycles = 0;
    while (!halt && cycles < prog.size() + 20) begin
      next_cycle();
      cycles++;
    end
    assert (halt) else begin
      $display("halt did not rise within %0d cycles after reset", cycles);
      test_errors++;
    end
    check_value("reg_a", reg_a, exp_regs[IDX_A]);
    check_value("reg_b", reg_b, exp_regs[IDX_B]);
    check_value("reg_c", reg_c, exp_regs[IDX_C]);
    check_value("reg_d", reg_d, exp_regs[IDX_D]);
    check_value("flags", {5'b0, flags}, {5'b0, 1'b1, exp_neg, exp_carry});
    check_value("pc", pc, exp_pc);
    if (check_hold) begin
      hold_pc = pc;
      repeat (HOLD_CYCLES) begin
        next_cycle();
        assert (halt) else begin
          $display("halt dropped after it was set");
          test_errors++;
        end
        check_value("pc", pc, hold_pc);
      end
    end
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %0d %s: %s", test_num, name, (test_errors == 0) ? "pass" : "fail");
    prog.delete();
  endtask

  initial begin
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;

    emit_ldi(IDX_A, rand_byte());
    emit_ldi(IDX_B, rand_byte());
    emit_ldi(IDX_C, rand_byte());
    emit_ldi(IDX_D, rand_byte());
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    run_test("ldi constants", 1'b0);

    // The ADD leaves flags that the moves must keep
    emit_ldi(IDX_A, rand_byte() | 8'h80);
    emit_ldi(IDX_B, rand_byte() | 8'h80);
    emit(`CPU_OP_ADD, IDX_A, IDX_B);
    emit(`CPU_OP_MOV, IDX_C, IDX_A);
    emit(`CPU_OP_MOV, IDX_D, IDX_B);
    emit(`CPU_OP_MOV, IDX_B, IDX_C);
    emit(`CPU_OP_MOV, IDX_A, IDX_D);
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    run_test("mov chain", 1'b0);

    emit_ldi(IDX_A, rand_byte() | 8'h80);
    emit_ldi(IDX_B, rand_byte());
    emit_ldi(IDX_C, rand_byte() | 8'h80);
    emit_ldi(IDX_D, rand_byte());
    emit(`CPU_OP_ADD, IDX_A, IDX_C);
    emit(`CPU_OP_ADC, IDX_B, IDX_D);
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    run_test("add adc carry", 1'b0);

    // D captures the borrow of the first SUB through ADC
    emit_ldi(IDX_A, rand_byte() & 8'h3f);
    emit_ldi(IDX_B, rand_byte() | 8'h80);
    emit_ldi(IDX_D, 8'h00);
    emit(`CPU_OP_SUB, IDX_A, IDX_B);
    emit(`CPU_OP_ADC, IDX_D, IDX_D);
    emit_ldi(IDX_C, rand_byte() | 8'h80);
    emit_ldi(IDX_B, rand_byte() & 8'h7f);
    emit(`CPU_OP_SUB, IDX_C, IDX_B);
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    run_test("sub borrow", 1'b0);

    // D holds 0xff so each ADC into A shows the carry left by the logic op before it
    // and sets the carry again for the next one
    emit_ldi(IDX_A, rand_byte() | 8'h80);
    emit_ldi(IDX_B, rand_byte() | 8'h80);
    emit_ldi(IDX_C, rand_byte());
    emit_ldi(IDX_D, 8'hff);
    emit(`CPU_OP_ADD, IDX_A, IDX_D);
    emit(`CPU_OP_AND, IDX_C, IDX_B);
    emit(4'd9, IDX_C, IDX_B);
    emit(`CPU_OP_ADC, IDX_A, IDX_D);
    emit(`CPU_OP_OR, IDX_C, IDX_A);
    emit(`CPU_OP_ADC, IDX_A, IDX_D);
    emit(`CPU_OP_XOR, IDX_B, IDX_C);
    emit(4'd14, IDX_A, IDX_B);
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    run_test("logic and undefined", 1'b0);

    // ADD and MOV are the two bytes in flight behind HLT
    emit_ldi(IDX_A, rand_byte());
    emit_ldi(IDX_B, rand_byte());
    emit(`CPU_OP_HLT, IDX_A, IDX_A);
    emit(`CPU_OP_ADD, IDX_A, IDX_B);
    emit(`CPU_OP_MOV, IDX_C, IDX_A);
    emit_ldi(IDX_A, rand_byte());
    run_test("halt hold", 1'b1);

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/execute_unit.sv
hw/cpu_top.sv
verification/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(BUILD_DIR)
